// ==== src/rtc_time_pkg.sv ====
// Time-of-day format: field widths, step widths and the one-second rollover value

package rtc_time_pkg;

    // =========================================================================
    // Time fields
    // =========================================================================

    // Seconds counter, free-running
    localparam int SEC_W = 32;

    // Nanoseconds counter, always held below one second
    localparam int NSEC_W = 30;

    // Rollover point of the nanosecond counter
    localparam logic [NSEC_W-1:0] NSEC_PER_SEC = 30'd1_000_000_000;

    // =========================================================================
    // Per-clock increment
    // =========================================================================

    // Whole nanoseconds and 1/256 ns fraction, same width for both
    localparam int INC_W = 8;

    // Whole part plus one extra nanosecond from the fraction carry
    localparam int STEP_W = INC_W + 1;

endpackage

// ==== src/rtc_cmd_pkg.sv ====
// Command encodings and sequencer states for the time-of-day counter

package rtc_cmd_pkg;

    // Operations accepted at the command port
    typedef enum logic [1:0] {
        OP_SET     = 2'd0,
        OP_ADJ_ADD = 2'd1,
        OP_ADJ_SUB = 2'd2,
        OP_SNAP    = 2'd3
    } rtc_op_e;

    // Sequencer FSM
    // IDLE waits for a strobe, ISSUE drives apply, SETTLE covers the update cycle
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_ISSUE  = 2'd1,
        ST_SETTLE = 2'd2
    } seq_state_e;

endpackage

// ==== src/rtc_cmd_if.sv ====
// Applied-command bus from the sequencer to the time core and the step accumulator

`timescale 1ns/1ps

interface rtc_cmd_if;

    // One-cycle strobe, command takes effect at the following edge
    logic apply;

    // Operation being applied
    rtc_cmd_pkg::rtc_op_e op;

    // Set value for seconds
    logic [rtc_time_pkg::SEC_W-1:0] sec;

    // Set value, or adjust offset, for nanoseconds
    logic [rtc_time_pkg::NSEC_W-1:0] nsec;

    // Sequencer side
    modport seq (
        output apply,
        output op,
        output sec,
        output nsec
    );

    // Time core consumes the whole command
    modport core (
        input apply,
        input op,
        input sec,
        input nsec
    );

    // Accumulator only needs to spot a set
    modport accum (
        input apply,
        input op
    );

endinterface

// ==== src/rtc_cmd_seq.sv ====
// Command sequencer FSM that accepts a strobe, applies it for one cycle and reports busy

`timescale 1ns/1ps

module rtc_cmd_seq (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                cmd_valid,
    input  rtc_cmd_pkg::rtc_op_e                cmd_op,
    input  logic [rtc_time_pkg::SEC_W-1:0]      cmd_sec,
    input  logic [rtc_time_pkg::NSEC_W-1:0]     cmd_nsec,
    output logic                                busy,
    rtc_cmd_if.seq                              cmd
);

    rtc_cmd_pkg::seq_state_e                state;
    rtc_cmd_pkg::seq_state_e                state_next;
    logic                                   accept;

    // Latched command held while the FSM is busy
    rtc_cmd_pkg::rtc_op_e                   op_q;
    logic [rtc_time_pkg::SEC_W-1:0]         sec_q;
    logic [rtc_time_pkg::NSEC_W-1:0]        nsec_q;

    // Strobes during ISSUE or SETTLE are dropped
    assign accept = cmd_valid && (state == rtc_cmd_pkg::ST_IDLE);

    // =========================================================================
    // FSM
    // =========================================================================

    always_comb begin
        state_next = state;
        case (state)
            rtc_cmd_pkg::ST_IDLE: begin
                if (accept) begin
                    state_next = rtc_cmd_pkg::ST_ISSUE;
                end
            end
            rtc_cmd_pkg::ST_ISSUE:  state_next = rtc_cmd_pkg::ST_SETTLE;
            rtc_cmd_pkg::ST_SETTLE: state_next = rtc_cmd_pkg::ST_IDLE;
            default:                state_next = rtc_cmd_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= rtc_cmd_pkg::ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Operands captured on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q   <= cmd_op;
            sec_q  <= cmd_sec;
            nsec_q <= cmd_nsec;
        end
    end

    // =========================================================================
    // Outputs
    // =========================================================================

    assign busy      = (state != rtc_cmd_pkg::ST_IDLE);
    assign cmd.apply = (state == rtc_cmd_pkg::ST_ISSUE);
    assign cmd.op    = op_q;
    assign cmd.sec   = sec_q;
    assign cmd.nsec  = nsec_q;

    // Apply only in the cycle right after an accepted strobe
    a_apply_issue: assert property (@(posedge clk) disable iff (rst)
        cmd.apply |-> $past(accept))
        else $error("apply without an accepted command in the cycle before");

    // Set values and adjust offsets must stay below one second
    a_nsec_legal: assert property (@(posedge clk) disable iff (rst)
        (accept && cmd_op != rtc_cmd_pkg::OP_SNAP) |-> (cmd_nsec < rtc_time_pkg::NSEC_PER_SEC))
        else $error("accepted nanosecond operand of one second or more");

endmodule

// ==== src/rtc_step_accum.sv ====
// Fractional-nanosecond accumulator that yields the per-clock nanosecond step

`timescale 1ns/1ps

module rtc_step_accum (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [rtc_time_pkg::INC_W-1:0]      inc_nsec,
    input  logic [rtc_time_pkg::INC_W-1:0]      inc_frac,
    rtc_cmd_if.accum                            cmd,
    output logic [rtc_time_pkg::STEP_W-1:0]     step
);

    logic [rtc_time_pkg::INC_W-1:0]     frac_q;
    logic [rtc_time_pkg::INC_W:0]       frac_sum;
    logic                               frac_carry;
    logic                               frac_clr;

    // Fraction in 1/256 ns, carry out is one extra nanosecond
    assign frac_sum   = {1'b0, frac_q} + {1'b0, inc_frac};
    assign frac_carry = frac_sum[rtc_time_pkg::INC_W];

    // A set restarts the fraction from zero
    assign frac_clr = cmd.apply && (cmd.op == rtc_cmd_pkg::OP_SET);

    always_ff @(posedge clk) begin
        if (rst) begin
            frac_q <= '0;
        end else if (frac_clr) begin
            frac_q <= '0;
        end else begin
            frac_q <= frac_sum[rtc_time_pkg::INC_W-1:0];
        end
    end

    assign step = {1'b0, inc_nsec} + {{rtc_time_pkg::INC_W{1'b0}}, frac_carry};

    // Extra nanosecond only when the fraction register wrapped at that edge
    a_step_carry: assert property (@(posedge clk) disable iff (rst)
        (step != {1'b0, inc_nsec}) |=>
            ($past(step) == $past({1'b0, inc_nsec}) + 1'b1) && (frac_q < $past(frac_q)))
        else $error("step differs from inc_nsec without a fraction carry");

endmodule

// ==== src/rtc_time_core.sv ====
// Seconds and nanoseconds counters with rollover, set, adjust, PPS and snapshot capture

`timescale 1ns/1ps

module rtc_time_core (
    input  logic                                clk,
    input  logic                                rst,
    rtc_cmd_if.core                             cmd,
    input  logic [rtc_time_pkg::STEP_W-1:0]     step,
    output logic [rtc_time_pkg::SEC_W-1:0]      rtc_sec,
    output logic [rtc_time_pkg::NSEC_W-1:0]     rtc_nsec,
    output logic                                pps,
    output logic                                snap_valid,
    output logic [rtc_time_pkg::SEC_W-1:0]      snap_sec,
    output logic [rtc_time_pkg::NSEC_W-1:0]     snap_nsec
);

    // Two spare bits keep current + step + offset under 2^31
    logic [rtc_time_pkg::NSEC_W+1:0]    nsec_base;
    logic [rtc_time_pkg::NSEC_W+1:0]    nsec_adj;
    logic [rtc_time_pkg::NSEC_W+1:0]    nsec_norm;
    logic [rtc_time_pkg::NSEC_W+1:0]    offset;
    logic [rtc_time_pkg::NSEC_W+1:0]    one_sec;
    logic                               is_set;
    logic                               is_add;
    logic                               is_sub;
    logic                               is_snap;
    logic                               carry;
    logic                               borrow;

    assign is_set  = cmd.apply && (cmd.op == rtc_cmd_pkg::OP_SET);
    assign is_add  = cmd.apply && (cmd.op == rtc_cmd_pkg::OP_ADJ_ADD);
    assign is_sub  = cmd.apply && (cmd.op == rtc_cmd_pkg::OP_ADJ_SUB);
    assign is_snap = cmd.apply && (cmd.op == rtc_cmd_pkg::OP_SNAP);

    assign offset  = {2'b00, cmd.nsec};
    assign one_sec = {2'b00, rtc_time_pkg::NSEC_PER_SEC};

    // =========================================================================
    // Next nanoseconds
    // =========================================================================

    // Free-running advance plus the offset on adjust-add
    assign nsec_base = {2'b00, rtc_nsec}
                     + {{(rtc_time_pkg::NSEC_W+2-rtc_time_pkg::STEP_W){1'b0}}, step}
                     + (is_add ? offset : '0);

    // Subtract wraps through one second when it would go negative
    assign borrow = is_sub && (nsec_base < offset);

    always_comb begin
        if (borrow) begin
            nsec_adj = nsec_base + one_sec - offset;
        end else if (is_sub) begin
            nsec_adj = nsec_base - offset;
        end else begin
            nsec_adj = nsec_base;
        end
    end

    // Sum is at most one second over and one subtract normalizes it
    assign carry     = (nsec_adj >= one_sec);
    assign nsec_norm = carry ? (nsec_adj - one_sec) : nsec_adj;

    // =========================================================================
    // Counters and PPS
    // =========================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            rtc_sec  <= '0;
            rtc_nsec <= '0;
            pps      <= 1'b0;
        end else if (is_set) begin
            rtc_sec  <= cmd.sec;
            rtc_nsec <= cmd.nsec;
            pps      <= 1'b0;
        end else begin
            rtc_nsec <= nsec_norm[rtc_time_pkg::NSEC_W-1:0];
            if (carry) begin
                rtc_sec <= rtc_sec + 1'b1;
            end else if (borrow) begin
                rtc_sec <= rtc_sec - 1'b1;
            end
            // Pulse on a forward rollover and never on a borrow
            pps <= carry;
        end
    end

    // Snapshot of the time before this edge's update
    always_ff @(posedge clk) begin
        if (rst) begin
            snap_valid <= 1'b0;
            snap_sec   <= '0;
            snap_nsec  <= '0;
        end else begin
            snap_valid <= is_snap;
            if (is_snap) begin
                snap_sec  <= rtc_sec;
                snap_nsec <= rtc_nsec;
            end
        end
    end

    a_nsec_range: assert property (@(posedge clk) disable iff (rst)
        rtc_nsec < rtc_time_pkg::NSEC_PER_SEC)
        else $error("nanosecond counter at or above one second");

endmodule

// ==== src/rtc_top.sv ====
// Time-of-day counter top level: command sequencer, step accumulator and time core

`timescale 1ns/1ps

module rtc_top (
    input  logic                                clk,
    input  logic                                rst,
    // Command port, strobe accepted only while busy is low
    input  logic                                cmd_valid,
    input  rtc_cmd_pkg::rtc_op_e                cmd_op,
    input  logic [rtc_time_pkg::SEC_W-1:0]      cmd_sec,
    input  logic [rtc_time_pkg::NSEC_W-1:0]     cmd_nsec,
    // Per-clock increment, whole ns and 1/256 ns
    input  logic [rtc_time_pkg::INC_W-1:0]      inc_nsec,
    input  logic [rtc_time_pkg::INC_W-1:0]      inc_frac,
    output logic                                busy,
    // Running time and pulse per second
    output logic [rtc_time_pkg::SEC_W-1:0]      rtc_sec,
    output logic [rtc_time_pkg::NSEC_W-1:0]     rtc_nsec,
    output logic                                pps,
    // Snapshot result
    output logic                                snap_valid,
    output logic [rtc_time_pkg::SEC_W-1:0]      snap_sec,
    output logic [rtc_time_pkg::NSEC_W-1:0]     snap_nsec
);

    rtc_cmd_if cmd_bus ();

    logic [rtc_time_pkg::STEP_W-1:0]    step;

    rtc_cmd_seq u_seq (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_sec   (cmd_sec),
        .cmd_nsec  (cmd_nsec),
        .busy      (busy),
        .cmd       (cmd_bus.seq)
    );

    rtc_step_accum u_accum (
        .clk       (clk),
        .rst       (rst),
        .inc_nsec  (inc_nsec),
        .inc_frac  (inc_frac),
        .cmd       (cmd_bus.accum),
        .step      (step)
    );

    rtc_time_core u_core (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd_bus.core),
        .step       (step),
        .rtc_sec    (rtc_sec),
        .rtc_nsec   (rtc_nsec),
        .pps        (pps),
        .snap_valid (snap_valid),
        .snap_sec   (snap_sec),
        .snap_nsec  (snap_nsec)
    );

endmodule

// ==== sim/rtc_tb.sv ====
// Testbench for the time-of-day counter: reference model, stimulus and checking assertions

`timescale 1ns/1ps

module rtc_tb;

    localparam int MAX_CYCLES = 3000;
    localparam longint ONE_SEC = 64'd1_000_000_000;

    logic                                clk = 1'b0;
    logic                                rst;
    logic                                cmd_valid;
    rtc_cmd_pkg::rtc_op_e                cmd_op;
    logic [rtc_time_pkg::SEC_W-1:0]      cmd_sec;
    logic [rtc_time_pkg::NSEC_W-1:0]     cmd_nsec;
    logic [rtc_time_pkg::INC_W-1:0]      inc_nsec;
    logic [rtc_time_pkg::INC_W-1:0]      inc_frac;
    logic                                busy;
    logic [rtc_time_pkg::SEC_W-1:0]      rtc_sec;
    logic [rtc_time_pkg::NSEC_W-1:0]     rtc_nsec;
    logic                                pps;
    logic                                snap_valid;
    logic [rtc_time_pkg::SEC_W-1:0]      snap_sec;
    logic [rtc_time_pkg::NSEC_W-1:0]     snap_nsec;

    // Reference model state
    logic [1:0]                          m_phase;
    rtc_cmd_pkg::rtc_op_e                m_op;
    logic [rtc_time_pkg::SEC_W-1:0]      m_set_sec;
    logic [rtc_time_pkg::NSEC_W-1:0]     m_opnd;
    logic [rtc_time_pkg::SEC_W-1:0]      m_sec;
    logic [rtc_time_pkg::NSEC_W-1:0]     m_nsec;
    logic [rtc_time_pkg::INC_W-1:0]      m_frac;
    logic                                m_pps;
    logic                                m_snap_valid;
    logic [rtc_time_pkg::SEC_W-1:0]      m_snap_sec;
    logic [rtc_time_pkg::NSEC_W-1:0]     m_snap_nsec;

    integer seed = 24548;
    int     cycles = 0;
    int     time_errs = 0;
    int     ctrl_errs = 0;
    int     snap_errs = 0;
    int     sum_errs = 0;

    rtc_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_sec    (cmd_sec),
        .cmd_nsec   (cmd_nsec),
        .inc_nsec   (inc_nsec),
        .inc_frac   (inc_frac),
        .busy       (busy),
        .rtc_sec    (rtc_sec),
        .rtc_nsec   (rtc_nsec),
        .pps        (pps),
        .snap_valid (snap_valid),
        .snap_sec   (snap_sec),
        .snap_nsec  (snap_nsec)
    );

    always #10 clk = ~clk;

    // ========================================================================
    // Reference model
    // ========================================================================

    always @(posedge clk) begin : ref_model
        longint total;
        int     fsum;
        logic   apply;
        fsum  = int'(m_frac) + int'(inc_frac);
        apply = (m_phase == 2'd1);
        // One extra nanosecond whenever the 1/256 ns fraction passes 255
        total = longint'(m_nsec) + longint'(inc_nsec) + ((fsum > 255) ? 64'd1 : 64'd0);
        if (rst) begin
            m_phase      <= 2'd0;
            m_sec        <= '0;
            m_nsec       <= '0;
            m_frac       <= '0;
            m_pps        <= 1'b0;
            m_snap_valid <= 1'b0;
            m_snap_sec   <= '0;
            m_snap_nsec  <= '0;
        end else begin
            case (m_phase)
                2'd0: begin
                    if (cmd_valid) begin
                        m_phase   <= 2'd1;
                        m_op      <= cmd_op;
                        m_set_sec <= cmd_sec;
                        m_opnd    <= cmd_nsec;
                    end
                end
                2'd1:    m_phase <= 2'd2;
                default: m_phase <= 2'd0;
            endcase
            m_frac       <= (apply && m_op == rtc_cmd_pkg::OP_SET) ? '0 : fsum[7:0];
            m_snap_valid <= apply && (m_op == rtc_cmd_pkg::OP_SNAP);
            if (apply && m_op == rtc_cmd_pkg::OP_SNAP) begin
                m_snap_sec  <= m_sec;
                m_snap_nsec <= m_nsec;
            end
            if (apply && m_op == rtc_cmd_pkg::OP_SET) begin
                m_sec  <= m_set_sec;
                m_nsec <= m_opnd;
                m_pps  <= 1'b0;
            end else begin
                if (apply && m_op == rtc_cmd_pkg::OP_ADJ_ADD) begin
                    total = total + longint'(m_opnd);
                end
                if (apply && m_op == rtc_cmd_pkg::OP_ADJ_SUB) begin
                    total = total - longint'(m_opnd);
                end
                if (total < 0) begin
                    total = total + ONE_SEC;
                    m_sec <= m_sec - 1'b1;
                    m_pps <= 1'b0;
                end else if (total >= ONE_SEC) begin
                    total = total - ONE_SEC;
                    m_sec <= m_sec + 1'b1;
                    m_pps <= 1'b1;
                end else begin
                    m_pps <= 1'b0;
                end
                m_nsec <= total[rtc_time_pkg::NSEC_W-1:0];
            end
        end
    end

    // ========================================================================
    // Checks
    // ========================================================================

    a_reset_state: assert property (@(posedge clk) $fell(rst) |->
        (!busy && !pps && !snap_valid && rtc_sec == '0 && rtc_nsec == '0
         && snap_sec == '0 && snap_nsec == '0))
        else begin
            ctrl_errs = ctrl_errs + 1;
            $display("ERROR %0t: outputs not cleared after reset", $time);
        end

    a_time: assert property (@(posedge clk) disable iff (rst)
        rtc_sec == m_sec && rtc_nsec == m_nsec)
        else begin
            time_errs = time_errs + 1;
            $display("ERROR %0t: time %0d.%09d, expected %0d.%09d", $time,
                     $sampled(rtc_sec), $sampled(rtc_nsec), $sampled(m_sec), $sampled(m_nsec));
        end

    a_ctrl: assert property (@(posedge clk) disable iff (rst)
        busy == (m_phase != 2'd0) && pps == m_pps)
        else begin
            ctrl_errs = ctrl_errs + 1;
            $display("ERROR %0t: busy %0b pps %0b, expected busy %0b pps %0b", $time,
                     $sampled(busy), $sampled(pps), $sampled(m_phase != 2'd0), $sampled(m_pps));
        end

    a_pps_once: assert property (@(posedge clk) disable iff (rst) pps |=> !pps)
        else begin
            ctrl_errs = ctrl_errs + 1;
            $display("ERROR %0t: pps high for more than one cycle", $time);
        end

    a_snap: assert property (@(posedge clk) disable iff (rst)
        snap_valid == m_snap_valid && snap_sec == m_snap_sec && snap_nsec == m_snap_nsec)
        else begin
            snap_errs = snap_errs + 1;
            $display("ERROR %0t: snapshot %0b %0d.%09d, expected %0b %0d.%09d", $time,
                     $sampled(snap_valid), $sampled(snap_sec), $sampled(snap_nsec),
                     $sampled(m_snap_valid), $sampled(m_snap_sec), $sampled(m_snap_nsec));
        end

    // Run limit, well above the total test length
    always @(posedge clk) begin : watchdog
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Run timed out after %0d cycles without finishing the tests", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // ========================================================================
    // Stimulus
    // ========================================================================

    task automatic run_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    function automatic logic [rtc_time_pkg::NSEC_W-1:0] rand_nsec();
        logic [31:0] r;
        r = $unsigned($random(seed)) % 32'd1_000_000_000;
        return r[rtc_time_pkg::NSEC_W-1:0];
    endfunction

    // Strobe for one cycle, then wait for the sequencer to go idle
    task automatic issue_cmd(input rtc_cmd_pkg::rtc_op_e op,
                             input logic [rtc_time_pkg::SEC_W-1:0] sec,
                             input logic [rtc_time_pkg::NSEC_W-1:0] nsec);
        @(negedge clk);
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_sec   = sec;
        cmd_nsec  = nsec;
        @(negedge clk);
        cmd_valid = 1'b0;
        while (busy) begin
            @(negedge clk);
        end
    endtask

    initial begin : stimulus
        logic [rtc_time_pkg::NSEC_W-1:0] start_nsec;
        int                              i;
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd_op    = rtc_cmd_pkg::OP_SET;
        cmd_sec   = '0;
        cmd_nsec  = '0;
        inc_nsec  = 8'd8;
        inc_frac  = '0;
        run_cycles(8);
        rst = 1'b0;

        // Whole-nanosecond step only
        run_cycles(20);

        // Quarter-nanosecond fraction, 64 carries over 256 edges
        inc_frac = 8'd64;
        issue_cmd(rtc_cmd_pkg::OP_SET, '0, '0);
        start_nsec = rtc_nsec;
        run_cycles(256);
        a_frac_sum: assert (int'(rtc_nsec - start_nsec) == 256 * int'(inc_nsec) + 64)
            else begin
                sum_errs = sum_errs + 1;
                $display("ERROR %0t: nanoseconds gained %0d over 256 cycles", $time,
                         rtc_nsec - start_nsec);
            end

        // Set just below one second and run through the rollover
        issue_cmd(rtc_cmd_pkg::OP_SET, 32'd5, rtc_time_pkg::NSEC_PER_SEC - 30'd20);
        run_cycles(8);

        // Random set, then random adjusts in both directions
        issue_cmd(rtc_cmd_pkg::OP_SET, $random(seed), rand_nsec());
        for (i = 0; i < 40; i++) begin
            if ($random(seed) & 1) begin
                issue_cmd(rtc_cmd_pkg::OP_ADJ_ADD, '0, rand_nsec());
            end else begin
                issue_cmd(rtc_cmd_pkg::OP_ADJ_SUB, '0, rand_nsec());
            end
            run_cycles(1 + ($unsigned($random(seed)) % 4));
        end

        // Snapshots while the counters keep running
        for (i = 0; i < 4; i++) begin
            issue_cmd(rtc_cmd_pkg::OP_SNAP, '0, '0);
            run_cycles(3 + i);
        end

        // Second strobe lands while busy and must be dropped
        @(negedge clk);
        cmd_valid = 1'b1;
        cmd_op    = rtc_cmd_pkg::OP_ADJ_ADD;
        cmd_nsec  = rand_nsec();
        @(negedge clk);
        cmd_op    = rtc_cmd_pkg::OP_SET;
        cmd_sec   = 32'd77;
        cmd_nsec  = 30'd7;
        @(negedge clk);
        cmd_valid = 1'b0;
        while (busy) begin
            @(negedge clk);
        end
        run_cycles(10);

        $display("Errors: time %0d, control %0d, snapshot %0d, fraction sum %0d",
                 time_errs, ctrl_errs, snap_errs, sum_errs);
        if (time_errs + ctrl_errs + snap_errs + sum_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== all.f ====
src/rtc_time_pkg.sv
src/rtc_cmd_pkg.sv
src/rtc_cmd_if.sv
src/rtc_cmd_seq.sv
src/rtc_step_accum.sv
src/rtc_time_core.sv
src/rtc_top.sv
sim/rtc_tb.sv

// ==== Makefile ====
# Verilator build for the time-of-day counter

LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f all.f --top-module rtc_tb

sim:
	verilator --binary --timing --assert -f all.f --top-module rtc_tb -o rtc_sim
	./obj_dir/rtc_sim | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG) || ! grep -q "RESULT: PASS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
